//--- files.f
+incdir+logic
logic/axi_pkg.sv
logic/cache_req_pkg.sv
logic/request_latch.sv
logic/read_engine.sv
logic/write_engine.sv
logic/axi_bridge_top.sv
verification/axi_bridge_properties.sv
verification/axi_bridge_tb.sv

//--- logic/axi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module axi_bridge_top (
    input  logic                     clk,
    input  logic                     rstn,
    // cache side
    input  cache_req_pkg::req_kind_e req,
    input  axi_pkg::addr_t           ad,
    input  cache_req_pkg::word_t     wword,
    input  cache_req_pkg::word_en_t  wword_en,
    input  cache_req_pkg::word_en_t  rword_en,
    output logic                     task_finish,
    output cache_req_pkg::block_t    rblock,
    output cache_req_pkg::word_t     rword,
    // read address
    output axi_pkg::id_t             arid,
    output axi_pkg::addr_t           araddr,
    output axi_pkg::len_t            arlen,
    output axi_pkg::size_t           arsize,
    output axi_pkg::burst_t          arburst,
    output logic [`LOCK_W-1:0]       arlock,
    output axi_pkg::cache_t          arcache,
    output logic [`PROT_W-1:0]       arprot,
    output logic                     arvalid,
    input  logic                     arready,
    // write address
    output axi_pkg::id_t             awid,
    output axi_pkg::addr_t           awaddr,
    output axi_pkg::len_t            awlen,
    output axi_pkg::size_t           awsize,
    output axi_pkg::burst_t          awburst,
    output logic [`LOCK_W-1:0]       awlock,
    output axi_pkg::cache_t          awcache,
    output logic [`PROT_W-1:0]       awprot,
    output logic                     awvalid,
    input  logic                     awready,
    // read data
    input  axi_pkg::data_t           rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,
    // write data and response
    output axi_pkg::id_t             wid,
    output axi_pkg::data_t           wdata,
    output axi_pkg::strb_t           wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    output logic                     bready,
    input  logic                     bvalid
);

    logic           load_start;
    logic           load_block;
    axi_pkg::addr_t load_addr;
    axi_pkg::size_t load_size;
    logic           load_done;
    logic           store_start;
    axi_pkg::addr_t store_addr;
    axi_pkg::data_t store_data;
    axi_pkg::strb_t store_strb;
    logic           store_done;

    // fields that never change
    assign arid    = `READ_ID;
    assign arlock  = `LOCK_NORMAL;
    assign arprot  = `PROT_DATA;
    assign awid    = `WRITE_ID;
    assign awlen   = '0;
    assign awsize  = `SIZE_WORD;
    assign awburst = `BURST_FIXED;
    assign awcache = `CACHE_NONE;
    assign awlock  = `LOCK_NORMAL;
    assign awprot  = `PROT_DATA;
    assign wid     = `WRITE_ID;

    request_latch request_latch_inst (
        .clk(clk),
        .rstn(rstn),
        .req(req),
        .ad(ad),
        .wword(wword),
        .wword_en(wword_en),
        .rword_en(rword_en),
        .load_done(load_done),
        .store_done(store_done),
        .load_start(load_start),
        .load_block(load_block),
        .load_addr(load_addr),
        .load_size(load_size),
        .store_start(store_start),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_strb(store_strb),
        .task_finish(task_finish)
    );

    read_engine read_engine_inst (
        .clk(clk),
        .rstn(rstn),
        .load_start(load_start),
        .load_block(load_block),
        .load_addr(load_addr),
        .load_size(load_size),
        .arready(arready),
        .rdata(rdata),
        .rvalid(rvalid),
        .rlast(rlast),
        .araddr(araddr),
        .arlen(arlen),
        .arsize(arsize),
        .arburst(arburst),
        .arcache(arcache),
        .arvalid(arvalid),
        .rready(rready),
        .rblock(rblock),
        .rword(rword),
        .load_done(load_done)
    );

    write_engine write_engine_inst (
        .clk(clk),
        .rstn(rstn),
        .store_start(store_start),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_strb(store_strb),
        .awready(awready),
        .wready(wready),
        .bvalid(bvalid),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .wdata(wdata),
        .wstrb(wstrb),
        .wlast(wlast),
        .wvalid(wvalid),
        .bready(bready),
        .store_done(store_done)
    );

endmodule

`default_nettype wire

//--- logic/axi_pkg.sv
`default_nettype none

`include "bridge_params.svh"

package axi_pkg;

    // address and data path
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`STRB_W-1:0] strb_t;

    // AXI3 burst control fields
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [3:0] cache_t;

    // read and write transactions use fixed ids
    typedef logic [3:0] id_t;

endpackage

`default_nettype wire

//--- logic/bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4
`define LOCK_W 2
`define PROT_W 3

// cache line geometry
`define BLOCK_BEATS 8
`define BLOCK_W 256
`define LINE_OFFSET_W 5
`define BEAT_CNT_W 3

// transaction ids
`define READ_ID 4'h0
`define WRITE_ID 4'h1

// axi field codes
`define BURST_FIXED 2'b00
`define BURST_INCR 2'b01
`define SIZE_BYTE 3'b000
`define SIZE_HALF 3'b001
`define SIZE_WORD 3'b010
`define CACHE_NONE 4'b0000
`define CACHE_CACHEABLE 4'b1111
`define LOCK_NORMAL 2'b00
`define PROT_DATA 3'b000

`endif

//--- logic/cache_req_pkg.sv
`default_nettype none

`include "bridge_params.svh"

package cache_req_pkg;

    // request kinds from the cache controller
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_LOAD_BLOCK,
        REQ_LOAD_WORD,
        REQ_STORE_WORD
    } req_kind_e;

    // one full line, beat 0 in the low word
    typedef logic [`BLOCK_W-1:0] block_t;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`STRB_W-1:0] word_en_t;

endpackage

`default_nettype wire

//--- logic/read_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module read_engine (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load_start,
    input  logic                   load_block,
    input  axi_pkg::addr_t         load_addr,
    input  axi_pkg::size_t         load_size,
    input  logic                   arready,
    input  axi_pkg::data_t         rdata,
    input  logic                   rvalid,
    input  logic                   rlast,
    output axi_pkg::addr_t         araddr,
    output axi_pkg::len_t          arlen,
    output axi_pkg::size_t         arsize,
    output axi_pkg::burst_t        arburst,
    output axi_pkg::cache_t        arcache,
    output logic                   arvalid,
    output logic                   rready,
    output cache_req_pkg::block_t  rblock,
    output cache_req_pkg::word_t   rword,
    output logic                   load_done
);

    localparam int unsigned LAST_IDX = `BLOCK_BEATS - 1;

    logic [`BEAT_CNT_W-1:0] beat_cnt;
    logic beat;
    logic last_beat;

    // a beat counts only when both sides agree
    assign beat = rvalid && rready;

    // refill ends on the eighth beat or an early rlast
    assign last_beat = !load_block || rlast || (beat_cnt == LAST_IDX[`BEAT_CNT_W-1:0]);

    // address channel valid
    always_ff @(posedge clk) begin
        if (!rstn) begin
            arvalid <= 1'b0;
        end else if (load_start) begin
            arvalid <= 1'b1;
        end else if (arvalid && arready) begin
            arvalid <= 1'b0;
        end
    end

    // address fields stay stable while arvalid is high
    always_ff @(posedge clk) begin
        if (load_start) begin
            araddr <= load_addr;
            if (load_block) begin
                arlen   <= axi_pkg::len_t'(LAST_IDX);
                arsize  <= `SIZE_WORD;
                arburst <= `BURST_INCR;
                arcache <= `CACHE_CACHEABLE;
            end else begin
                arlen   <= '0;
                arsize  <= load_size;
                arburst <= `BURST_FIXED;
                arcache <= `CACHE_NONE;
            end
        end
    end

    // data channel control and beat count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rready    <= 1'b0;
            beat_cnt  <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (load_start) begin
                rready   <= 1'b1;
                beat_cnt <= '0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    rready    <= 1'b0;
                    load_done <= 1'b1;
                end
            end
        end
    end

    // beat i lands in word i of the line
    always_ff @(posedge clk) begin
        if (beat) begin
            if (load_block) begin
                rblock[beat_cnt * `DATA_W +: `DATA_W] <= rdata;
            end else begin
                rword <= rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/request_latch.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module request_latch (
    input  logic                     clk,
    input  logic                     rstn,
    input  cache_req_pkg::req_kind_e req,
    input  axi_pkg::addr_t           ad,
    input  cache_req_pkg::word_t     wword,
    input  cache_req_pkg::word_en_t  wword_en,
    input  cache_req_pkg::word_en_t  rword_en,
    input  logic                     load_done,
    input  logic                     store_done,
    output logic                     load_start,
    output logic                     load_block,
    output axi_pkg::addr_t           load_addr,
    output axi_pkg::size_t           load_size,
    output logic                     store_start,
    output axi_pkg::addr_t           store_addr,
    output axi_pkg::data_t           store_data,
    output axi_pkg::strb_t           store_strb,
    output logic                     task_finish
);

    logic busy;
    logic accept;
    axi_pkg::size_t word_size;

    // requests are dropped while a task is open
    assign accept = (req != cache_req_pkg::REQ_NONE) && !busy;

    // transfer size of an uncached load
    always_comb begin
        case (rword_en)
            4'b1111: word_size = `SIZE_WORD;
            4'b1100, 4'b0011: word_size = `SIZE_HALF;
            default: word_size = `SIZE_BYTE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy        <= 1'b0;
            load_start  <= 1'b0;
            store_start <= 1'b0;
            task_finish <= 1'b0;
        end else begin
            load_start  <= accept && (req == cache_req_pkg::REQ_LOAD_BLOCK ||
                                      req == cache_req_pkg::REQ_LOAD_WORD);
            store_start <= accept && (req == cache_req_pkg::REQ_STORE_WORD);
            task_finish <= load_done || store_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (load_done || store_done) begin
                busy <= 1'b0;
            end
        end
    end

    // request payload, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            load_block <= (req == cache_req_pkg::REQ_LOAD_BLOCK);
            if (req == cache_req_pkg::REQ_LOAD_BLOCK) begin
                // refill starts at the line boundary
                load_addr <= {ad[`ADDR_W-1:`LINE_OFFSET_W], {`LINE_OFFSET_W{1'b0}}};
                load_size <= `SIZE_WORD;
            end else begin
                load_addr <= ad;
                load_size <= word_size;
            end
            store_addr <= ad;
            store_data <= wword;
            store_strb <= wword_en;
        end
    end

endmodule

`default_nettype wire

//--- logic/write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module write_engine (
    input  logic           clk,
    input  logic           rstn,
    input  logic           store_start,
    input  axi_pkg::addr_t store_addr,
    input  axi_pkg::data_t store_data,
    input  axi_pkg::strb_t store_strb,
    input  logic           awready,
    input  logic           wready,
    input  logic           bvalid,
    output axi_pkg::addr_t awaddr,
    output logic           awvalid,
    output axi_pkg::data_t wdata,
    output axi_pkg::strb_t wstrb,
    output logic           wlast,
    output logic           wvalid,
    output logic           bready,
    output logic           store_done
);

    logic aw_done;
    logic w_done;

    // single beat store, so every data beat is the last
    assign wlast = wvalid;

    // address and data channels finish independently
    always_ff @(posedge clk) begin
        if (!rstn) begin
            awvalid <= 1'b0;
            aw_done <= 1'b0;
            wvalid  <= 1'b0;
            w_done  <= 1'b0;
        end else if (store_start) begin
            awvalid <= 1'b1;
            aw_done <= 1'b0;
            wvalid  <= 1'b1;
            w_done  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                aw_done <= 1'b1;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
                w_done <= 1'b1;
            end
            // flags go back to idle with the response
            if (bready && bvalid) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    // response channel opens once both handshakes are done
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bready     <= 1'b0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            if (bready && bvalid) begin
                bready     <= 1'b0;
                store_done <= 1'b1;
            end else if (aw_done && w_done) begin
                bready <= 1'b1;
            end
        end
    end

    // payload held stable while the valids are up
    always_ff @(posedge clk) begin
        if (store_start) begin
            awaddr <= store_addr;
            wdata  <= store_data;
            wstrb  <= store_strb;
        end
    end

endmodule

`default_nettype wire

//--- verification/axi_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bridge_properties (
    input logic           clk,
    input logic           rstn,
    input logic           arvalid,
    input logic           arready,
    input axi_pkg::addr_t araddr,
    input logic           awvalid,
    input logic           awready,
    input axi_pkg::addr_t awaddr,
    input logic           wvalid,
    input logic           wready,
    input axi_pkg::data_t wdata,
    input axi_pkg::strb_t wstrb,
    input logic           wlast,
    input logic           task_finish
);

    // count of failed assertions
    int failures = 0;

    // a raised valid waits for its ready with the address held
    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            failures++;
            $error("arvalid dropped or araddr moved before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            failures++;
            $error("awvalid dropped or awaddr moved before awready");
        end

    // single beat store keeps its last beat and payload until wready
    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && wlast && $stable(wdata) && $stable(wstrb))
        else begin
            failures++;
            $error("wvalid dropped or write data moved before wready");
        end

    // finish is a single cycle pulse
    finish_pulse: assert property (@(posedge clk) disable iff (!rstn)
        task_finish |=> !task_finish)
        else begin
            failures++;
            $error("task_finish high for two cycles");
        end

endmodule

bind axi_bridge_top axi_bridge_properties axi_bridge_properties_inst (
    .clk(clk),
    .rstn(rstn),
    .arvalid(arvalid),
    .arready(arready),
    .araddr(araddr),
    .awvalid(awvalid),
    .awready(awready),
    .awaddr(awaddr),
    .wvalid(wvalid),
    .wready(wready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wlast(wlast),
    .task_finish(task_finish)
);

`default_nettype wire

//--- verification/axi_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module axi_bridge_tb;

    localparam int NUM_REQ = 200;
    localparam int TIMEOUT = 200;

    logic clk;
    logic rstn;
    cache_req_pkg::req_kind_e req;
    axi_pkg::addr_t ad;
    cache_req_pkg::word_t wword;
    cache_req_pkg::word_en_t wword_en;
    cache_req_pkg::word_en_t rword_en;
    logic task_finish;
    cache_req_pkg::block_t rblock;
    cache_req_pkg::word_t rword;
    axi_pkg::id_t arid, awid, wid;
    axi_pkg::addr_t araddr, awaddr;
    axi_pkg::len_t arlen, awlen;
    axi_pkg::size_t arsize, awsize;
    axi_pkg::burst_t arburst, awburst;
    axi_pkg::cache_t arcache, awcache;
    logic [`LOCK_W-1:0] arlock, awlock;
    logic [`PROT_W-1:0] arprot, awprot;
    logic arvalid, awvalid, wvalid, wlast, rready, bready;
    axi_pkg::data_t wdata;
    axi_pkg::strb_t wstrb;

    // memory model outputs
    logic arready = 1'b0;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic bvalid = 1'b0;
    logic rvalid = 1'b0;
    logic rlast = 1'b0;
    axi_pkg::data_t rdata = '0;

    // memory model state
    axi_pkg::data_t mem [int unsigned];
    integer seed;
    integer delay_seed;
    int unsigned ar_delay = 0, r_delay = 0, aw_delay = 0, w_delay = 0, b_delay = 0;
    logic r_active = 1'b0, aw_got = 1'b0, w_got = 1'b0, w_last = 1'b0;
    int r_cnt = 0;
    axi_pkg::addr_t ar_addr, aw_addr;
    axi_pkg::len_t ar_len;
    axi_pkg::size_t ar_size;
    axi_pkg::burst_t ar_burst;
    axi_pkg::cache_t ar_cache;
    axi_pkg::data_t w_data;
    axi_pkg::strb_t w_strb;

    int ar_count = 0, aw_count = 0, finish_count = 0;
    int exp_ar = 0, exp_aw = 0, tasks_done = 0;
    int value_errors = 0, seq_errors = 0, timeouts = 0;

    axi_bridge_top axi_bridge_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned next_delay();
        return $unsigned($random(delay_seed)) % 4;
    endfunction

    // untouched words read back a pattern of their own address
    function automatic axi_pkg::data_t mem_read(input axi_pkg::addr_t addr);
        if (mem.exists(addr[7:2])) begin
            return mem[addr[7:2]];
        end
        return addr ^ {addr[7:0], addr[15:8], addr[23:16], addr[31:24]} ^ 32'h5a5a_0f0f;
    endfunction

    task automatic mem_write(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
                             input axi_pkg::strb_t strb);
        axi_pkg::data_t word;
        word = mem_read(addr);
        for (int b = 0; b < `STRB_W; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[addr[7:2]] = word;
    endtask

    // AXI slave with random ready and valid delays
    always @(posedge clk) begin
        if (!rstn) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            r_active <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_delay <= next_delay();
                r_active <= 1'b1;
                r_cnt <= 0;
                ar_addr <= araddr;
                ar_len <= arlen;
                ar_size <= arsize;
                ar_burst <= arburst;
                ar_cache <= arcache;
                ar_count <= ar_count + 1;
            end else if (arvalid) begin
                if (ar_delay == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_delay <= ar_delay - 1;
                end
            end
            if (r_active) begin
                if (rvalid && rready) begin
                    rvalid <= 1'b0;
                    rlast <= 1'b0;
                    r_delay <= next_delay();
                    r_cnt <= r_cnt + 1;
                    if (r_cnt == ar_len) begin
                        r_active <= 1'b0;
                    end
                end else if (!rvalid) begin
                    if (r_delay == 0) begin
                        rvalid <= 1'b1;
                        rlast <= (r_cnt == ar_len);
                        // incrementing bursts step one word per beat
                        rdata <= mem_read(ar_burst == `BURST_INCR ? ar_addr + 4 * r_cnt : ar_addr);
                    end else begin
                        r_delay <= r_delay - 1;
                    end
                end
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_delay <= next_delay();
                aw_got <= 1'b1;
                aw_addr <= awaddr;
                aw_count <= aw_count + 1;
            end else if (awvalid) begin
                if (aw_delay == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_delay <= aw_delay - 1;
                end
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_delay <= next_delay();
                w_got <= 1'b1;
                w_data <= wdata;
                w_strb <= wstrb;
                w_last <= wlast;
            end else if (wvalid) begin
                if (w_delay == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_delay <= w_delay - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got <= 1'b0;
                b_delay <= next_delay();
            end else if (aw_got && w_got && !bvalid) begin
                if (b_delay == 0) begin
                    bvalid <= 1'b1;
                    mem_write(aw_addr, w_data, w_strb);
                end else begin
                    b_delay <= b_delay - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && task_finish) begin
            finish_count <= finish_count + 1;
        end
    end

    task automatic check_block(input string name, input cache_req_pkg::block_t got,
                               input cache_req_pkg::block_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input cache_req_pkg::word_t got,
                              input cache_req_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input axi_pkg::addr_t got,
                              input axi_pkg::addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input axi_pkg::strb_t got,
                              input axi_pkg::strb_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input axi_pkg::len_t got,
                             input axi_pkg::len_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input axi_pkg::size_t got,
                              input axi_pkg::size_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_burst(input string name, input axi_pkg::burst_t got,
                               input axi_pkg::burst_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cache(input string name, input axi_pkg::cache_t got,
                               input axi_pkg::cache_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input axi_pkg::id_t got,
                            input axi_pkg::id_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_lock(input string name, input logic [`LOCK_W-1:0] got,
                              input logic [`LOCK_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_prot(input string name, input logic [`PROT_W-1:0] got,
                              input logic [`PROT_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        check_bit("bready", bready, 1'b0);
        check_bit("task_finish", task_finish, 1'b0);
    endtask

    // AXI fields tied to constant codes
    task automatic check_tied_fields();
        check_id("arid", arid, `READ_ID);
        check_lock("arlock", arlock, `LOCK_NORMAL);
        check_prot("arprot", arprot, `PROT_DATA);
        check_id("awid", awid, `WRITE_ID);
        check_id("wid", wid, `WRITE_ID);
        check_len("awlen", awlen, 8'd0);
        check_size("awsize", awsize, `SIZE_WORD);
        check_burst("awburst", awburst, `BURST_FIXED);
        check_cache("awcache", awcache, `CACHE_NONE);
        check_lock("awlock", awlock, `LOCK_NORMAL);
        check_prot("awprot", awprot, `PROT_DATA);
    endtask

    // uncached load size from the byte enables
    function automatic axi_pkg::size_t size_for(input cache_req_pkg::word_en_t en);
        if (en == 4'b1111) begin
            return `SIZE_WORD;
        end
        if (en == 4'b1100 || en == 4'b0011) begin
            return `SIZE_HALF;
        end
        return `SIZE_BYTE;
    endfunction

    task automatic wait_finish(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT) begin
            @(posedge clk);
            req <= cache_req_pkg::REQ_NONE;
            cycles++;
            if (task_finish) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic run_request(output bit ok);
        cache_req_pkg::req_kind_e kind;
        axi_pkg::addr_t addr;
        axi_pkg::addr_t base;
        cache_req_pkg::word_t data;
        cache_req_pkg::word_en_t wen;
        cache_req_pkg::word_en_t ren;
        cache_req_pkg::block_t exp_block;
        int unsigned pick;
        pick = $unsigned($random(seed)) % 3;
        case (pick)
            0: kind = cache_req_pkg::REQ_LOAD_BLOCK;
            1: kind = cache_req_pkg::REQ_LOAD_WORD;
            default: kind = cache_req_pkg::REQ_STORE_WORD;
        endcase
        // word ops stay word aligned inside the 64 word memory
        addr = $random(seed) & 32'h0000_00ff;
        if (kind != cache_req_pkg::REQ_LOAD_BLOCK) begin
            addr[1:0] = 2'b00;
        end
        data = $random(seed);
        wen = cache_req_pkg::word_en_t'($random(seed));
        ren = cache_req_pkg::word_en_t'($random(seed));
        ad <= addr;
        wword <= data;
        wword_en <= wen;
        rword_en <= ren;
        req <= kind;
        @(posedge clk);
        // sometimes a second request while busy that must be dropped
        if ($random(seed) & 1) begin
            req <= ($random(seed) & 1) ? cache_req_pkg::REQ_LOAD_BLOCK
                                       : cache_req_pkg::REQ_STORE_WORD;
            ad <= $random(seed);
        end else begin
            req <= cache_req_pkg::REQ_NONE;
        end
        wait_finish(ok);
        if (!ok) begin
            timeouts++;
            $display("No task_finish within %0d cycles of request %0d", TIMEOUT, tasks_done);
        end else begin
            @(posedge clk);
            tasks_done++;
            if (kind == cache_req_pkg::REQ_STORE_WORD) begin
                exp_aw++;
            end else begin
                exp_ar++;
            end
            if (finish_count != tasks_done) begin
                seq_errors++;
                $display("Saw %0d task_finish pulses after %0d requests", finish_count,
                         tasks_done);
            end
            if (ar_count != exp_ar || aw_count != exp_aw) begin
                seq_errors++;
                $display("Saw %0d reads and %0d writes on AXI where %0d and %0d were expected",
                         ar_count, aw_count, exp_ar, exp_aw);
            end
            case (kind)
                cache_req_pkg::REQ_LOAD_BLOCK: begin
                    base = {addr[`ADDR_W-1:5], 5'b00000};
                    for (int i = 0; i < `BLOCK_BEATS; i++) begin
                        exp_block[32*i +: 32] = mem_read(base + 4 * i);
                    end
                    check_addr("araddr", ar_addr, base);
                    check_len("arlen", ar_len, 8'd7);
                    check_burst("arburst", ar_burst, `BURST_INCR);
                    check_size("arsize", ar_size, `SIZE_WORD);
                    check_cache("arcache", ar_cache, `CACHE_CACHEABLE);
                    check_block("rblock", rblock, exp_block);
                end
                cache_req_pkg::REQ_LOAD_WORD: begin
                    check_addr("araddr", ar_addr, addr);
                    check_len("arlen", ar_len, 8'd0);
                    check_burst("arburst", ar_burst, `BURST_FIXED);
                    check_size("arsize", ar_size, size_for(ren));
                    check_cache("arcache", ar_cache, `CACHE_NONE);
                    check_word("rword", rword, mem_read(addr));
                end
                default: begin
                    check_addr("awaddr", aw_addr, addr);
                    check_word("wdata", w_data, data);
                    check_strb("wstrb", w_strb, wen);
                    check_bit("wlast", w_last, 1'b1);
                end
            endcase
            check_tied_fields();
        end
    endtask

    initial begin
        bit ok;
        int assert_fails;
        seed = 32'h9dd4_7670;
        delay_seed = seed ^ 32'h3c3c_a5a5;
        rstn = 1'b0;
        req = cache_req_pkg::REQ_NONE;
        ad = '0;
        wword = '0;
        wword_en = '0;
        rword_en = '0;
        ok = 1'b1;
        repeat (2) @(posedge clk);
        check_idle();
        rstn <= 1'b1;
        @(posedge clk);
        check_idle();
        @(posedge clk);
        check_idle();
        for (int n = 0; n < NUM_REQ && ok; n++) begin
            run_request(ok);
        end
        // a stray pulse after the last task would show here
        repeat (4) @(posedge clk);
        if (finish_count != tasks_done) begin
            seq_errors++;
            $display("Saw %0d task_finish pulses for %0d requests", finish_count, tasks_done);
        end
        assert_fails = axi_bridge_top_inst.axi_bridge_properties_inst.failures;
        $display("Errors: %0d value, %0d sequence, %0d timeout, %0d assertion",
                 value_errors, seq_errors, timeouts, assert_fails);
        if (value_errors + seq_errors + timeouts + assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
